/* src/heapPkg.sv */
//----------------------------------------
// Shared widths, opcodes, error classes and
// the request, decoded and response words of
// the heap engine. Referenced by scoped names
//----------------------------------------
package heapPkg;

  // Geometry ------------------------------
  localparam int arrayBits   = 3;                     // Bits in an array number
  localparam int arrays      = 8;                     // Arrays in the heap
  localparam int indexBits   = 3;                     // Bits in an element index
  localparam int arrayLength = 8;                     // Elements per array
  localparam int dataBits    = 16;                    // Element width
  localparam int sizeBits    = indexBits + 1;         // Holds 0 to arrayLength
  localparam int addressBits = arrayBits + indexBits; // Flat element address

  // Encodings -----------------------------
  typedef enum logic [3:0] {
    opAlloc    = 4'd0,                                // New array number
    opFree     = 4'd1,                                // Return array for reuse
    opWrite    = 4'd2,                                // Store element, may grow
    opRead     = 4'd3,                                // Fetch element
    opSize     = 4'd4,                                // Current size
    opPush     = 4'd5,                                // Append at end
    opPop      = 4'd6,                                // Remove from end
    opAdd      = 4'd7,                                // Returns new value
    opAddAfter = 4'd8,                                // Returns old value
    opSub      = 4'd9,                                // Returns new value
    opSubAfter = 4'd10,                               // Returns old value
    opBitNot   = 4'd11,
    opBitAnd   = 4'd12,
    opBitOr    = 4'd13,
    opBitXor   = 4'd14
  } opCode;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                           // Number never handed out
    errFreed        = 3'd2,                           // Handed out then freed
    errOutOfBounds  = 3'd3,                           // Index at or past size
    errFull         = 3'd4,                           // Push on full array
    errEmpty        = 3'd5,                           // Pop on empty array
    errOutOfMemory  = 3'd6                            // No array left to hand out
  } errorClass;

  // Pipeline words ------------------------
  typedef struct packed {
    opCode                 op;
    logic [arrayBits-1:0]  array;
    logic [indexBits-1:0]  index;
    logic [dataBits-1:0]   data;
  } heapRequest;                                      // 26 bits

  typedef struct packed {
    opCode                  op;
    logic [arrayBits-1:0]   array;                    // Alloc puts new number here
    logic [indexBits-1:0]   index;
    logic [dataBits-1:0]    data;
    errorClass              error;
    logic [addressBits-1:0] address;                  // Element the item touches
    logic [sizeBits-1:0]    size;                     // Size before this request
  } decodedOp;

  typedef struct packed {
    logic [dataBits-1:0] data;
    errorClass           error;
  } heapResponse;                                     // 19 bits

endpackage

/* src/heapArrayTable.sv */
//----------------------------------------
// Array bookkeeping for the heap. Holds the
// allocation bits, sizes, the handed out count
// and the stack of freed arrays
//----------------------------------------
`timescale 1ns/1ps

module heapArrayTable (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic [heapPkg::arrayBits-1:0] array,        // Array being asked about
  input  logic                          allocate,     // Hand out allocNumber
  input  logic                          releaseArray, // Free array
  input  logic                          sizeWrite,    // Load newSize for array
  input  logic [heapPkg::sizeBits-1:0]  newSize,
  output logic                          allocated,    // Currently live
  output logic                          everUsed,     // Number handed out at some time
  output logic [heapPkg::sizeBits-1:0]  size,
  output logic [heapPkg::arrayBits-1:0] allocNumber,  // Array an alloc would get
  output logic                          allocFails    // Nothing left to hand out
);

  logic [heapPkg::arrays-1:0]    allocBits;                          // Live arrays
  logic [heapPkg::sizeBits-1:0]  sizes     [heapPkg::arrays];        // Size per array
  logic [heapPkg::arrayBits-1:0] freeStack [heapPkg::arrays];        // Freed numbers
  logic [heapPkg::sizeBits-1:0]  usedCount;                          // Numbers handed out
  logic [heapPkg::sizeBits-1:0]  freeTop;                            // Entries on stack
  logic [heapPkg::arrayBits-1:0] topIndex;                           // Newest freed entry
  logic                          stackEmpty;

  // Lookups -------------------------------
  assign topIndex    = heapPkg::arrayBits'(freeTop - heapPkg::sizeBits'(1));
  assign stackEmpty  = (freeTop == '0);
  assign allocated   = allocBits[array];
  assign everUsed    = ({1'b0, array} < usedCount);
  assign size        = sizes[array];
  assign allocNumber = stackEmpty ? usedCount[heapPkg::arrayBits-1:0]  // Fresh number
                                  : freeStack[topIndex];               // Reuse newest
  assign allocFails  = stackEmpty && (usedCount == heapPkg::sizeBits'(heapPkg::arrays));

  // State ---------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocBits <= '0;                                               // Heap empty
      usedCount <= '0;
      freeTop   <= '0;
      for (int i = 0; i < heapPkg::arrays; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      if (allocate) begin
        allocBits[allocNumber] <= 1'b1;
        sizes[allocNumber]     <= '0;                                // New array is empty
        if (stackEmpty) begin
          usedCount <= usedCount + heapPkg::sizeBits'(1);
        end else begin
          freeTop   <= freeTop - heapPkg::sizeBits'(1);              // Pop freed number
        end
      end
      if (releaseArray) begin
        allocBits[array] <= 1'b0;
        freeTop          <= freeTop + heapPkg::sizeBits'(1);
      end
      if (sizeWrite) begin
        sizes[array] <= newSize;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (releaseArray) begin
      freeStack[freeTop[heapPkg::arrayBits-1:0]] <= array;           // Push freed number
    end
  end

  // Decode rejects double frees, so the stack cannot outgrow the heap
  assert property (@(posedge clock) disable iff (!resetN)
    freeTop <= heapPkg::sizeBits'(heapPkg::arrays))
    else $error("Free stack holds more than %0d entries", heapPkg::arrays);

endmodule

/* src/heapDecode.sv */
//----------------------------------------
// Request stage. Checks each request against
// the array table, commands the table update
// and registers the decoded item for execute
//----------------------------------------
`timescale 1ns/1ps

module heapDecode (
  input  logic                clock,
  input  logic                resetN,
  input  heapPkg::heapRequest request,
  input  logic                reqValid,
  output logic                reqReady,
  input  logic                stall,                         // Response register blocked
  output heapPkg::decodedOp   decoded,
  output logic                decodedValid
);

  logic                          accept;                     // Request transfers
  logic                          allocated, everUsed, allocFails;
  logic [heapPkg::sizeBits-1:0]  tableSize, newSize;
  logic [heapPkg::sizeBits-1:0]  indexPlusOne, sizeMinusOne;
  logic [heapPkg::arrayBits-1:0] allocNumber;
  logic                          isAlloc, isElement, changesSize;
  heapPkg::errorClass            error;
  heapPkg::decodedOp             item;

  heapArrayTable u_heapArrayTable (
    .clock        (clock),
    .resetN       (resetN),
    .array        (request.array),
    .allocate     (accept && isAlloc && error == heapPkg::errNone),
    .releaseArray (accept && request.op == heapPkg::opFree && error == heapPkg::errNone),
    .sizeWrite    (accept && changesSize && error == heapPkg::errNone),
    .newSize      (newSize),
    .allocated    (allocated),
    .everUsed     (everUsed),
    .size         (tableSize),
    .allocNumber  (allocNumber),
    .allocFails   (allocFails)
  );

  assign reqReady = !stall;
  assign accept   = reqValid && reqReady;

  // Classify ------------------------------
  assign isAlloc     = (request.op == heapPkg::opAlloc);
  assign isElement   = (request.op == heapPkg::opRead) || (request.op >= heapPkg::opAdd);
  assign changesSize = (request.op == heapPkg::opWrite) || (request.op == heapPkg::opPush) ||
                       (request.op == heapPkg::opPop);

  assign indexPlusOne = heapPkg::sizeBits'(request.index) + heapPkg::sizeBits'(1);
  assign sizeMinusOne = tableSize - heapPkg::sizeBits'(1);

  always_comb begin
    error = heapPkg::errNone;                                // Checks in priority order
    if (isAlloc) begin
      if (allocFails) error = heapPkg::errOutOfMemory;
    end else if (!everUsed) begin
      error = heapPkg::errNotAllocated;
    end else if (!allocated) begin
      error = heapPkg::errFreed;
    end else if (isElement && {1'b0, request.index} >= tableSize) begin
      error = heapPkg::errOutOfBounds;
    end else if (request.op == heapPkg::opPush &&
                 tableSize == heapPkg::sizeBits'(heapPkg::arrayLength)) begin
      error = heapPkg::errFull;
    end else if (request.op == heapPkg::opPop && tableSize == '0) begin
      error = heapPkg::errEmpty;
    end
  end

  always_comb begin
    case (request.op)
      heapPkg::opPush: newSize = tableSize + heapPkg::sizeBits'(1);
      heapPkg::opPop:  newSize = sizeMinusOne;
      default:         newSize = (indexPlusOne > tableSize) ? indexPlusOne : tableSize;
    endcase
  end

  always_comb begin
    item         = '0;
    item.op      = request.op;
    item.array   = isAlloc ? allocNumber : request.array;    // Alloc returns its number
    item.index   = request.index;
    item.data    = request.data;
    item.error   = error;
    item.size    = tableSize;
    case (request.op)
      heapPkg::opPush: item.address = {request.array, tableSize[heapPkg::indexBits-1:0]};
      heapPkg::opPop:  item.address = {request.array, sizeMinusOne[heapPkg::indexBits-1:0]};
      default:         item.address = {request.array, request.index};
    endcase
  end

  // Decoded register ----------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      decodedValid <= 1'b0;
    end else if (!stall) begin
      decodedValid <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) decoded <= item;                             // Held while stalled
  end

  // A committed size never runs past the end of an array
  assert property (@(posedge clock) disable iff (!resetN)
    accept && changesSize && error == heapPkg::errNone |->
      newSize <= heapPkg::sizeBits'(heapPkg::arrayLength))
    else $error("Size update to %0d exceeds the array length", newSize);

endmodule

/* src/heapExecute.sv */
//----------------------------------------
// Element memory of the heap. Reads the addressed
// element, forms the response combinationally and
// writes back when the item advances
//----------------------------------------
`timescale 1ns/1ps

module heapExecute (
  input  logic                 clock,
  input  heapPkg::decodedOp    decoded,
  input  logic                 decodedValid,
  input  logic                 advance,                      // Response register loads
  output heapPkg::heapResponse response
);

  logic [heapPkg::dataBits-1:0] mem [heapPkg::arrays * heapPkg::arrayLength]; // Blocks of 8
  logic [heapPkg::dataBits-1:0] oldValue, newValue;
  logic                         storesElement;
  logic                         writeEnable;

  assign oldValue = mem[decoded.address];

  // Arithmetic ----------------------------
  always_comb begin
    storesElement = 1'b1;
    case (decoded.op)
      heapPkg::opWrite,
      heapPkg::opPush:     newValue = decoded.data;          // Plain store
      heapPkg::opAdd,
      heapPkg::opAddAfter: newValue = oldValue + decoded.data; // Wraps at 16 bits
      heapPkg::opSub,
      heapPkg::opSubAfter: newValue = oldValue - decoded.data;
      heapPkg::opBitNot:   newValue = ~oldValue;
      heapPkg::opBitAnd:   newValue = oldValue & decoded.data;
      heapPkg::opBitOr:    newValue = oldValue | decoded.data;
      heapPkg::opBitXor:   newValue = oldValue ^ decoded.data;
      default: begin
        newValue      = oldValue;                            // No element change
        storesElement = 1'b0;
      end
    endcase
  end

  // Returned value ------------------------
  always_comb begin
    response.error = decoded.error;
    case (decoded.op)
      heapPkg::opAlloc:    response.data = heapPkg::dataBits'(decoded.array);
      heapPkg::opFree:     response.data = '0;
      heapPkg::opSize:     response.data = heapPkg::dataBits'(decoded.size);
      heapPkg::opRead,
      heapPkg::opPop,
      heapPkg::opAddAfter,
      heapPkg::opSubAfter: response.data = oldValue;         // Value before change
      default:             response.data = newValue;
    endcase
    if (decoded.error != heapPkg::errNone) begin
      response.data = '0;                                    // Errors return zero
    end
  end

  assign writeEnable = decodedValid && advance && storesElement &&
                       (decoded.error == heapPkg::errNone);

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      mem[decoded.address] <= newValue;                      // Lands with the response load
    end
  end

endmodule

/* src/heapResult.sv */
//----------------------------------------
// Response register. Holds one result until
// the client takes it with respReady
//----------------------------------------
`timescale 1ns/1ps

module heapResult (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::heapResponse response,                     // From execute
  input  logic                 load,                         // Valid item advancing
  output heapPkg::heapResponse resp,
  output logic                 respValid,
  input  logic                 respReady
);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respValid <= 1'b0;
    end else if (load) begin
      respValid <= 1'b1;                                     // New result replaces old
    end else if (respReady) begin
      respValid <= 1'b0;                                     // Taken, nothing behind
    end
  end

  always_ff @(posedge clock) begin
    if (load) resp <= response;
  end

  // Back-pressure must hold the pending response intact
  assert property (@(posedge clock) disable iff (!resetN)
    respValid && !respReady |=> respValid && $stable(resp))
    else $error("Response changed while waiting for respReady");

endmodule

/* src/heapMemory.sv */
//----------------------------------------
// Heap engine top. Joins decode, execute and
// result and forms the shared pipeline stall
//----------------------------------------
`timescale 1ns/1ps

module heapMemory (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::heapRequest  request,
  input  logic                 reqValid,
  output logic                 reqReady,
  output heapPkg::heapResponse resp,
  output logic                 respValid,
  input  logic                 respReady
);

  logic                 stall;                               // Response not taken
  logic                 decodedValid;
  heapPkg::decodedOp    decoded;
  heapPkg::heapResponse executeResponse;

  assign stall = respValid && !respReady;

  heapDecode u_heapDecode (
    .clock        (clock),
    .resetN       (resetN),
    .request      (request),
    .reqValid     (reqValid),
    .reqReady     (reqReady),
    .stall        (stall),
    .decoded      (decoded),
    .decodedValid (decodedValid)
  );

  heapExecute u_heapExecute (
    .clock        (clock),
    .decoded      (decoded),
    .decodedValid (decodedValid),
    .advance      (!stall),
    .response     (executeResponse)
  );

  heapResult u_heapResult (
    .clock     (clock),
    .resetN    (resetN),
    .response  (executeResponse),
    .load      (decodedValid && !stall),                     // Item moves to output
    .resp      (resp),
    .respValid (respValid),
    .respReady (respReady)
  );

endmodule

/* test/heapClock.sv */
//----------------------------------------
// Testbench clock and reset. 100 ns period,
// reset held low for the first 16 cycles
//----------------------------------------
`timescale 1ns/1ps

module heapClock (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;                   // 100 ns period
  end

  initial begin
    resetN = 1'b0;                                // Heap starts empty
    repeat (16) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;                                // Release away from rising edge
  end

endmodule

/* test/heapTb.sv */
//----------------------------------------
// Heap engine testbench. Reads request vectors
// with expected responses, drives them with random
// gaps and back-pressure, and checks in order
//----------------------------------------
`timescale 1ns/1ps

module heapTb;

  localparam int    cyclesPerVector = 40;         // Watchdog budget per vector
  localparam int    resetCycles     = 16;
  localparam string dataFile        = "test/heapTestdata.txt";

  logic                 clock, resetN;
  heapPkg::heapRequest  request;
  logic                 reqValid, reqReady;
  heapPkg::heapResponse resp;
  logic                 respValid, respReady;

  heapPkg::heapRequest vectors[$];                // Requests in file order
  logic [15:0]         expectData[$];
  logic [2:0]          expectError[$];
  int                  vectorCount;
  int                  passCount, failCount;

  heapClock u_heapClock (
    .clock  (clock),
    .resetN (resetN)
  );

  heapMemory u_heapMemory (
    .clock     (clock),
    .resetN    (resetN),
    .request   (request),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .resp      (resp),
    .respValid (respValid),
    .respReady (respReady)
  );

  // Vector file ---------------------------
  task automatic readVectors();
    int                  fd;
    int                  fields;
    string               line;
    logic [3:0]          op;
    logic [2:0]          arr, idx, err;
    logic [15:0]         data, expected;
    heapPkg::heapRequest r;
    fd = $fopen(dataFile, "r");
    if (fd == 0) begin
      $display("Could not open the test data file %s", dataFile);
      failCount++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) != "#") begin      // Skip comment lines
        fields = $sscanf(line, "%h %h %h %h %h %h", op, arr, idx, data, expected, err);
        if (fields == 6) begin
          r.op    = heapPkg::opCode'(op);
          r.array = arr;
          r.index = idx;
          r.data  = data;
          vectors.push_back(r);
          expectData.push_back(expected);
          expectError.push_back(err);
        end
      end
    end
    $fclose(fd);
    vectorCount = vectors.size();
  endtask

  // Compare one transferred response with its vector
  task automatic checkResponse(input int n);
    if (resp.data !== expectData[n] || resp.error !== expectError[n]) begin
      $display("[FAIL] %0t ns vector %0d %s: got data %h error %0d, expected data %h error %0d",
               $time, n, vectors[n].op.name(), resp.data, resp.error,
               expectData[n], expectError[n]);
      failCount++;
    end else begin
      $display("[PASS] vector %0d %s array %0d data %h error %0d",
               n, vectors[n].op.name(), vectors[n].array, resp.data, resp.error);
      passCount++;
    end
  endtask

  // Stimulus and checking -----------------
  initial begin : stimulus
    int sent;                                     // Requests accepted so far
    int received;                                 // Responses taken so far
    int lowCycles;                                // Remaining back-pressure stretch
    bit reqTaken, respTaken;
    void'($urandom(60523));
    request     = '0;
    reqValid    = 1'b0;
    respReady   = 1'b0;
    passCount   = 0;
    failCount   = 0;
    vectorCount = 0;
    sent        = 0;
    received    = 0;
    lowCycles   = 0;
    reqTaken    = 1'b0;
    readVectors();
    if (vectorCount == 0) begin
      $display("No test vectors were read, nothing to run");
      failCount++;
    end
    wait (resetN === 1'b1);
    while (received < vectorCount) begin
      @(negedge clock);
      if (reqTaken) sent++;                       // Transferred on last rising edge
      if (!reqValid || reqTaken) begin
        if (sent < vectorCount && $urandom % 4 != 0) begin
          request  = vectors[sent];
          reqValid = 1'b1;
        end else begin
          request  = '0;                          // Idle gap
          reqValid = 1'b0;
        end
      end
      if (lowCycles > 0) begin
        lowCycles--;
      end else if ($urandom % 5 == 0) begin
        lowCycles = 1 + $urandom % 6;             // Start a stall stretch
      end
      respReady = (lowCycles == 0);
      #1;                                         // Handshake inputs settled
      reqTaken  = reqValid && reqReady;
      respTaken = respValid && respReady;
      if (respTaken) begin
        if (received >= sent) begin
          $display("Response arrived at %0t ns with no request outstanding", $time);
          failCount++;
        end else begin
          checkResponse(received);
        end
        received++;
      end
    end
    @(negedge clock);
    request   = '0;
    reqValid  = 1'b0;
    respReady = 1'b1;
    repeat (4) begin                              // Nothing may follow the last response
      @(negedge clock);
      #1;
      if (respValid) begin
        $display("Extra response at %0t ns after the last vector", $time);
        failCount++;
      end
    end
    $display("Vectors: %0d passed, %0d checks failed, %0d in file",
             passCount, failCount, vectorCount);
    if (failCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog ------------------------------
  initial begin : watchdog
    wait (vectorCount > 0);
    repeat (resetCycles + vectorCount * cyclesPerVector) @(posedge clock);
    $display("Watchdog expired, responses stopped arriving before all %0d vectors finished",
             vectorCount);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* build.f */
src/heapPkg.sv
src/heapArrayTable.sv
src/heapDecode.sv
src/heapExecute.sv
src/heapResult.sv
src/heapMemory.sv
test/heapClock.sv
test/heapTb.sv

/* Makefile */
# Verilator build and run of the heap engine testbench
VERILATOR ?= verilator
TOP       ?= heapTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST OK

SOURCES := $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/heapTestdata.txt */
# Columns in hex: op array index data expectedData expectedError
# op 0 alloc 1 free 2 write 3 read 4 size 5 push 6 pop 7 add 8 addAfter 9 sub A subAfter B..E not and or xor
# Unallocated access, then alloc and reuse
3 0 0 0000 0000 1
2 5 1 BEEF 0000 1
0 0 0 0000 0000 0
0 0 0 0000 0001 0
0 0 0 0000 0002 0
1 1 0 0000 0000 0
0 0 0 0000 0001 0
# Write, size and read on array 0
2 0 2 1234 1234 0
4 0 0 0000 0003 0
3 0 3 0000 0000 3
3 0 2 0000 1234 0
# In-place arithmetic on array 0 index 2
7 0 2 0010 1244 0
8 0 2 0001 1244 0
3 0 2 0000 1245 0
9 0 2 0245 1000 0
A 0 2 1001 1000 0
3 0 2 0000 FFFF 0
7 0 2 0003 0002 0
B 0 2 0000 FFFD 0
C 0 2 F0F0 F0F0 0
D 0 2 0F00 FFF0 0
E 0 2 00FF FF0F 0
7 0 5 0001 0000 3
# Push array 2 to full, then pop
5 2 0 0A00 0A00 0
5 2 0 0A01 0A01 0
5 2 0 0A02 0A02 0
5 2 0 0A03 0A03 0
5 2 0 0A04 0A04 0
5 2 0 0A05 0A05 0
5 2 0 0A06 0A06 0
5 2 0 0A07 0A07 0
5 2 0 0A08 0000 4
4 2 0 0000 0008 0
6 2 0 0000 0A07 0
6 2 0 0000 0A06 0
6 2 0 0000 0A05 0
4 2 0 0000 0005 0
6 1 0 0000 0000 5
# Allocate the rest, then run out
0 0 0 0000 0003 0
0 0 0 0000 0004 0
0 0 0 0000 0005 0
0 0 0 0000 0006 0
0 0 0 0000 0007 0
0 0 0 0000 0000 6
# Freed array misuse, state left unchanged
1 1 0 0000 0000 0
3 1 0 0000 0000 2
1 1 0 0000 0000 2
5 1 0 ABCD 0000 2
0 0 0 0000 0001 0
4 1 0 0000 0000 0
3 0 2 0000 FF0F 0
